// ==== list.f ====
pipeline_types.sv
pc.sv
id.sv
regfile.sv
dispatch.sv
ex.sv
mem.sv
ctrl.sv
cpu_core.sv
cpu_checker.sv
tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_cpu_core \
    --Mdir obj_dir -o sim_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cpu_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== tb_cpu_core.sv ====
module tb_cpu_core;
    import pipeline_types::*;

    localparam bus32_t RESET_PC = RESET_PC_DEFAULT;
    localparam int     TIMEOUT_CYCLES = 5000;

    logic       clk;
    logic       rst_i;
    bus32_t     rom [256];
    bus32_t     ram [64];
    bus32_t     rom_inst;
    bus32_t     ram_rdata;
    bus32_t     pc;
    logic       inst_en;
    bus32_t     ram_addr;
    bus32_t     ram_wdata;
    logic       ram_we;
    logic       ram_re;
    logic [3:0] ram_sel;
    logic       ram_en;
    logic       wb_valid;
    bus32_t     wb_pc;
    logic       wb_we;
    reg_addr_t  wb_addr;
    bus32_t     wb_data;

    int   seed;
    int   cycles;
    logic timed_out;
    int   errors;
    int   checks;
    int   commits;
    logic done;

    function automatic bus32_t rnd(input int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    // random program from the supported subset, r0..r7 only
    task automatic build_program();
        bus32_t kind;
        bus32_t rd;
        bus32_t rj;
        bus32_t rk;
        bus32_t off;
        for (int i = 0; i < 255; i++) begin
            kind = rnd(12);
            rd   = rnd(8);
            rj   = rnd(8);
            rk   = rnd(8);
            if (kind >= 10 && i >= 252) begin
                // no room left for a forward branch
                kind = 6;
            end
            case (kind)
                0:  rom[i] = 32'h0010_0000 | (rk << 10) | (rj << 5) | rd;
                1:  rom[i] = 32'h0011_0000 | (rk << 10) | (rj << 5) | rd;
                2:  rom[i] = 32'h0012_0000 | (rk << 10) | (rj << 5) | rd;
                3:  rom[i] = 32'h0014_8000 | (rk << 10) | (rj << 5) | rd;
                4:  rom[i] = 32'h0015_0000 | (rk << 10) | (rj << 5) | rd;
                5:  rom[i] = 32'h0015_8000 | (rk << 10) | (rj << 5) | rd;
                6:  rom[i] = 32'h0280_0000 | (rnd(4096) << 10) | (rj << 5) | rd;
                7:  rom[i] = 32'h1400_0000 | (rnd(32'h10_0000) << 5) | rd;
                8:  rom[i] = 32'h2880_0000 | ((rnd(64) << 2) << 10) | rd;
                9:  rom[i] = 32'h2980_0000 | ((rnd(64) << 2) << 10) | rd;
                10: begin
                    off    = rnd(4) + 32'd1;
                    rom[i] = (rnd(2) == 0 ? 32'h5800_0000 : 32'h5c00_0000)
                             | (off << 10) | (rj << 5) | rd;
                end
                default: begin
                    off    = rnd(4) + 32'd1;
                    rom[i] = 32'h5000_0000 | (off << 10);
                end
            endcase
        end
        // b 0 spins on the last word
        rom[255] = 32'h5000_0000;
    endtask

    task automatic fill_ram();
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'h7f00_0000 ^ (32'(i) * 32'h0001_0203);
        end
    endtask

    always #50 clk = ~clk;

    assign rom_inst  = rom[8'((pc - RESET_PC) >> 2)];
    assign ram_rdata = ram[ram_addr[7:2]];

    always @(posedge clk) begin
        if (ram_we && ram_sel == 4'b1111) begin
            ram[ram_addr[7:2]] <= ram_wdata;
        end
    end

    cpu_core #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk(clk),
        .rst_i(rst_i),
        .rom_inst_i(rom_inst),
        .pc_o(pc),
        .inst_en_o(inst_en),
        .ram_read_data_i(ram_rdata),
        .ram_addr_o(ram_addr),
        .ram_write_data_o(ram_wdata),
        .ram_write_en_o(ram_we),
        .ram_read_en_o(ram_re),
        .ram_select_o(ram_sel),
        .ram_en_o(ram_en),
        .wb_valid_o(wb_valid),
        .wb_pc_o(wb_pc),
        .wb_reg_write_en_o(wb_we),
        .wb_reg_addr_o(wb_addr),
        .wb_reg_data_o(wb_data)
    );

    cpu_checker #(
        .RESET_PC(RESET_PC),
        .COMMIT_TARGET(200)
    ) i_checker (
        .clk(clk),
        .rst_i(rst_i),
        .rom_i(rom),
        .ram_i(ram),
        .pc_o(pc),
        .inst_en_o(inst_en),
        .ram_addr_o(ram_addr),
        .ram_write_data_o(ram_wdata),
        .ram_write_en_o(ram_we),
        .ram_read_en_o(ram_re),
        .ram_en_o(ram_en),
        .ram_select_o(ram_sel),
        .wb_valid_o(wb_valid),
        .wb_pc_o(wb_pc),
        .wb_reg_write_en_o(wb_we),
        .wb_reg_addr_o(wb_addr),
        .wb_reg_data_o(wb_data),
        .errors_o(errors),
        .checks_o(checks),
        .commits_o(commits),
        .done_o(done)
    );

    initial begin
        clk       = 1'b0;
        rst_i     = 1'b1;
        timed_out = 1'b0;
        seed      = 32'h0a25_52ae;
        build_program();
        fill_ram();
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("the core stopped committing, no end after %0d cycles", TIMEOUT_CYCLES);
        end
        $display("commits %0d, checks %0d, errors %0d", commits, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== cpu_checker.sv ====
module cpu_checker #(
    parameter pipeline_types::bus32_t RESET_PC = pipeline_types::RESET_PC_DEFAULT,
    parameter int COMMIT_TARGET = 200
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  pipeline_types::bus32_t    rom_i [256],
    input  pipeline_types::bus32_t    ram_i [64],
    input  pipeline_types::bus32_t    pc_o,
    input  logic                      inst_en_o,
    input  pipeline_types::bus32_t    ram_addr_o,
    input  pipeline_types::bus32_t    ram_write_data_o,
    input  logic                      ram_write_en_o,
    input  logic                      ram_read_en_o,
    input  logic                      ram_en_o,
    input  logic [3:0]                ram_select_o,
    input  logic                      wb_valid_o,
    input  pipeline_types::bus32_t    wb_pc_o,
    input  logic                      wb_reg_write_en_o,
    input  pipeline_types::reg_addr_t wb_reg_addr_o,
    input  pipeline_types::bus32_t    wb_reg_data_o,
    output int                        errors_o,
    output int                        checks_o,
    output int                        commits_o,
    output logic                      done_o
);
    import pipeline_types::*;

    localparam bus32_t LOOP_PC = RESET_PC + 32'd1020;

    bus32_t     model_regs [32];
    bus32_t     model_mem [64];
    bus32_t     model_pc = RESET_PC;
    int         err_cnt = 0;
    int         chk_cnt = 0;
    int         commit_cnt = 0;
    int         post_cnt = 0;
    logic       rst_q = 1'b0;
    bus32_t     st_addr_q [$];
    bus32_t     st_data_q [$];
    logic [3:0] st_sel_q [$];
    bus32_t     ld_addr_q [$];
    logic [3:0] ld_sel_q [$];

    assign errors_o  = err_cnt;
    assign checks_o  = chk_cnt;
    assign commits_o = commit_cnt;
    assign done_o    = commit_cnt >= COMMIT_TARGET || model_pc == LOOP_PC;

    task automatic check_value(input string name, input bus32_t exp, input bus32_t act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("** Error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // architectural step of one instruction, compared with the commit port
    task automatic commit_model();
        bus32_t    inst;
        bus32_t    next_pc;
        bus32_t    wdata;
        bus32_t    addr;
        bus32_t    imm12;
        bus32_t    vj;
        bus32_t    vk;
        bus32_t    vd;
        bus32_t    off;
        logic      we;
        reg_addr_t rd;
        inst    = rom_i[8'((model_pc - RESET_PC) >> 2)];
        rd      = inst[4:0];
        vj      = model_regs[inst[9:5]];
        vk      = model_regs[inst[14:10]];
        vd      = model_regs[rd];
        imm12   = {{20{inst[21]}}, inst[21:10]};
        addr    = vj + imm12;
        next_pc = model_pc + 32'd4;
        we      = 1'b1;
        wdata   = '0;
        off     = '0;
        case (1'b1)
            inst[31:15] == 17'h00020: wdata = vj + vk;
            inst[31:15] == 17'h00022: wdata = vj - vk;
            inst[31:15] == 17'h00024: wdata = ($signed(vj) < $signed(vk)) ? 32'd1 : 32'd0;
            inst[31:15] == 17'h00029: wdata = vj & vk;
            inst[31:15] == 17'h0002a: wdata = vj | vk;
            inst[31:15] == 17'h0002b: wdata = vj ^ vk;
            inst[31:22] == 10'h00a:   wdata = vj + imm12;
            inst[31:25] == 7'h0a:     wdata = {inst[24:5], 12'h000};
            inst[31:22] == 10'h0a2: begin
                if (ld_addr_q.size() == 0) begin
                    err_cnt++;
                    $display("load at pc %h committed without a read on the RAM port",
                             model_pc);
                end else begin
                    check_value("ram_addr_o", addr, ld_addr_q.pop_front());
                    check_value("ram_select_o", 32'hf, {28'd0, ld_sel_q.pop_front()});
                end
                wdata = model_mem[addr[7:2]];
            end
            inst[31:22] == 10'h0a6: begin
                we = 1'b0;
                if (st_addr_q.size() == 0) begin
                    err_cnt++;
                    $display("store at pc %h committed without a write on the RAM port",
                             model_pc);
                end else begin
                    check_value("ram_addr_o", addr, st_addr_q.pop_front());
                    check_value("ram_write_data_o", vd, st_data_q.pop_front());
                    check_value("ram_select_o", 32'hf, {28'd0, st_sel_q.pop_front()});
                end
                model_mem[addr[7:2]] = vd;
            end
            inst[31:26] == 6'h16, inst[31:26] == 6'h17: begin
                we  = 1'b0;
                off = {{14{inst[25]}}, inst[25:10], 2'b00};
                if ((vj == vd) == (inst[31:26] == 6'h16)) begin
                    next_pc = model_pc + off;
                end
            end
            inst[31:26] == 6'h14: begin
                we      = 1'b0;
                next_pc = model_pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            end
            default: we = 1'b0;
        endcase
        we = we && rd != 5'd0;
        check_value("wb_pc_o", model_pc, wb_pc_o);
        check_value("wb_reg_write_en_o", {31'd0, we}, {31'd0, wb_reg_write_en_o});
        if (we) begin
            check_value("wb_reg_addr_o", {27'd0, rd}, {27'd0, wb_reg_addr_o});
            check_value("wb_reg_data_o", wdata, wb_reg_data_o);
            model_regs[rd] = wdata;
        end
        model_pc = next_pc;
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            if (rst_q) begin
                check_value("pc_o", RESET_PC, pc_o);
                check_value("inst_en_o", 32'd0, {31'd0, inst_en_o});
                check_value("wb_valid_o", 32'd0, {31'd0, wb_valid_o});
                check_value("ram_en_o", 32'd0, {31'd0, ram_en_o});
            end
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                model_mem[i] = ram_i[i];
            end
            model_pc = RESET_PC;
            st_addr_q.delete();
            st_data_q.delete();
            st_sel_q.delete();
            ld_addr_q.delete();
            ld_sel_q.delete();
            post_cnt = 0;
        end else begin
            if (post_cnt == 0) begin
                check_value("pc_o", RESET_PC, pc_o);
            end
            if (post_cnt == 1) begin
                check_value("inst_en_o", 32'd1, {31'd0, inst_en_o});
            end
            post_cnt++;
            if (wb_valid_o) begin
                commit_model();
                commit_cnt++;
            end
            // store shows up on the RAM port one cycle before its commit
            if (ram_write_en_o) begin
                check_value("ram_en_o", 32'd1, {31'd0, ram_en_o});
                st_addr_q.push_back(ram_addr_o);
                st_data_q.push_back(ram_write_data_o);
                st_sel_q.push_back(ram_select_o);
            end
            // same for a load read
            if (ram_read_en_o) begin
                check_value("ram_en_o", 32'd1, {31'd0, ram_en_o});
                ld_addr_q.push_back(ram_addr_o);
                ld_sel_q.push_back(ram_select_o);
            end
        end
        rst_q = rst_i;
    end

endmodule

// ==== cpu_core.sv ====
module cpu_core #(
    parameter pipeline_types::bus32_t RESET_PC = pipeline_types::RESET_PC_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst_i,

    input  pipeline_types::bus32_t    rom_inst_i,
    output pipeline_types::bus32_t    pc_o,
    output logic                      inst_en_o,

    input  pipeline_types::bus32_t    ram_read_data_i,
    output pipeline_types::bus32_t    ram_addr_o,
    output pipeline_types::bus32_t    ram_write_data_o,
    output logic                      ram_write_en_o,
    output logic                      ram_read_en_o,
    output logic [3:0]                ram_select_o,
    output logic                      ram_en_o,

    output logic                      wb_valid_o,
    output pipeline_types::bus32_t    wb_pc_o,
    output logic                      wb_reg_write_en_o,
    output pipeline_types::reg_addr_t wb_reg_addr_o,
    output pipeline_types::bus32_t    wb_reg_data_o
);
    import pipeline_types::*;

    ctrl_t         ctrl;
    logic          branch_flush;
    bus32_t        branch_target;
    logic          pause_dispatch;

    id_dispatch_t  id_out;
    dispatch_ex_t  dispatch_out;
    ex_mem_t       ex_out;
    mem_wb_t       wb;
    push_forward_t ex_forward;
    push_forward_t mem_forward;

    reg_addr_t     reg1_addr;
    reg_addr_t     reg2_addr;
    bus32_t        reg1_data;
    bus32_t        reg2_data;

    pc #(
        .RESET_PC(RESET_PC)
    ) u_pc (
        .clk,
        .rst_i,
        .ctrl_i(ctrl),
        .branch_flush_i(branch_flush),
        .branch_target_i(branch_target),
        .pc_o(pc_o),
        .inst_en_o(inst_en_o)
    );

    id u_id (
        .clk,
        .rst_i,
        .ctrl_i(ctrl),
        .pc_i(pc_o),
        .inst_i(rom_inst_i),
        .id_o(id_out)
    );

    dispatch u_dispatch (
        .clk,
        .rst_i,
        .ctrl_i(ctrl),
        .id_i(id_out),
        .reg1_data_i(reg1_data),
        .reg2_data_i(reg2_data),
        .ex_forward_i(ex_forward),
        .mem_forward_i(mem_forward),
        .reg1_addr_o(reg1_addr),
        .reg2_addr_o(reg2_addr),
        .pause_dispatch_o(pause_dispatch),
        .dispatch_o(dispatch_out)
    );

    regfile u_regfile (
        .clk,
        .rst_i,
        .reg1_addr_i(reg1_addr),
        .reg2_addr_i(reg2_addr),
        .we_i(wb.valid && wb.reg_write_en),
        .waddr_i(wb.reg_write_addr),
        .wdata_i(wb.reg_write_data),
        .reg1_data_o(reg1_data),
        .reg2_data_o(reg2_data)
    );

    ex u_ex (
        .clk,
        .rst_i,
        .dispatch_i(dispatch_out),
        .ex_forward_o(ex_forward),
        .branch_flush_o(branch_flush),
        .branch_target_o(branch_target),
        .ex_o(ex_out)
    );

    mem u_mem (
        .clk,
        .rst_i,
        .ex_i(ex_out),
        .ram_read_data_i(ram_read_data_i),
        .ram_addr_o(ram_addr_o),
        .ram_write_data_o(ram_write_data_o),
        .ram_write_en_o(ram_write_en_o),
        .ram_read_en_o(ram_read_en_o),
        .ram_en_o(ram_en_o),
        .ram_select_o(ram_select_o),
        .mem_forward_o(mem_forward),
        .mem_o(wb)
    );

    ctrl u_ctrl (
        .pause_dispatch_i(pause_dispatch),
        .branch_flush_i(branch_flush),
        .ctrl_o(ctrl)
    );

    // commit port
    assign wb_valid_o        = wb.valid;
    assign wb_pc_o           = wb.pc;
    assign wb_reg_write_en_o = wb.reg_write_en;
    assign wb_reg_addr_o     = wb.reg_write_addr;
    assign wb_reg_data_o     = wb.reg_write_data;

endmodule

// ==== ctrl.sv ====
module ctrl (
    input  logic                  pause_dispatch_i,
    input  logic                  branch_flush_i,
    output pipeline_types::ctrl_t ctrl_o
);

    logic stall;

    // a flush drops the stalled instruction anyway
    assign stall = pause_dispatch_i && !branch_flush_i;

    assign ctrl_o.stall_pc       = stall;
    assign ctrl_o.stall_id       = stall;
    assign ctrl_o.stall_dispatch = stall;
    assign ctrl_o.flush          = branch_flush_i;

endmodule

// ==== mem.sv ====
module mem (
    input  logic                          clk,
    input  logic                          rst_i,
    input  pipeline_types::ex_mem_t       ex_i,
    input  pipeline_types::bus32_t        ram_read_data_i,
    output pipeline_types::bus32_t        ram_addr_o,
    output pipeline_types::bus32_t        ram_write_data_o,
    output logic                          ram_write_en_o,
    output logic                          ram_read_en_o,
    output logic                          ram_en_o,
    output logic [3:0]                    ram_select_o,
    output pipeline_types::push_forward_t mem_forward_o,
    output pipeline_types::mem_wb_t       mem_o
);
    import pipeline_types::*;

    bus32_t wb_data;

    assign ram_read_en_o    = ex_i.valid && ex_i.aluop == ALU_LD;
    assign ram_write_en_o   = ex_i.valid && ex_i.aluop == ALU_ST;
    assign ram_en_o         = ram_read_en_o || ram_write_en_o;
    // word access only
    assign ram_select_o     = ram_en_o ? 4'b1111 : 4'b0000;
    assign ram_addr_o       = ex_i.mem_addr;
    assign ram_write_data_o = ex_i.store_data;

    assign wb_data = ram_read_en_o ? ram_read_data_i : ex_i.reg_write_data;

    assign mem_forward_o = '{
        aluop:          ex_i.aluop,
        reg_write_en:   ex_i.reg_write_en,
        reg_write_addr: ex_i.reg_write_addr,
        reg_write_data: wb_data
    };

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_o.valid        <= 1'b0;
            mem_o.reg_write_en <= 1'b0;
        end else begin
            mem_o <= '{pc: ex_i.pc, reg_write_en: ex_i.reg_write_en,
                       reg_write_addr: ex_i.reg_write_addr, reg_write_data: wb_data,
                       valid: ex_i.valid};
        end
    end

endmodule

// ==== ex.sv ====
module ex (
    input  logic                          clk,
    input  logic                          rst_i,
    input  pipeline_types::dispatch_ex_t  dispatch_i,
    output pipeline_types::push_forward_t ex_forward_o,
    output logic                          branch_flush_o,
    output pipeline_types::bus32_t        branch_target_o,
    output pipeline_types::ex_mem_t       ex_o
);
    import pipeline_types::*;

    bus32_t  op1;
    bus32_t  op2;
    bus32_t  result;
    bus32_t  mem_addr;
    logic    taken;
    ex_mem_t ex_next;

    assign op1      = dispatch_i.operand1;
    assign op2      = dispatch_i.operand2;
    assign mem_addr = op1 + dispatch_i.imm;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (dispatch_i.aluop)
            ALU_ADD: result = op1 + op2;
            ALU_SUB: result = op1 - op2;
            ALU_AND: result = op1 & op2;
            ALU_OR:  result = op1 | op2;
            ALU_XOR: result = op1 ^ op2;
            ALU_SLT: result = {31'd0, $signed(op1) < $signed(op2)};
            ALU_LUI: result = dispatch_i.imm << 12;
            ALU_BEQ: taken = (op1 == op2);
            ALU_BNE: taken = (op1 != op2);
            ALU_B:   taken = 1'b1;
            default: ;
        endcase
    end

    // offs16 and offs26 both count words
    assign branch_target_o = dispatch_i.pc + {dispatch_i.imm[29:0], 2'b00};
    assign branch_flush_o  = dispatch_i.valid && taken;

    assign ex_next = '{
        pc:             dispatch_i.pc,
        aluop:          dispatch_i.aluop,
        mem_addr:       mem_addr,
        store_data:     dispatch_i.store_data,
        reg_write_en:   dispatch_i.reg_write_en,
        reg_write_addr: dispatch_i.reg_write_addr,
        reg_write_data: result,
        valid:          dispatch_i.valid
    };

    assign ex_forward_o = '{
        aluop:          dispatch_i.aluop,
        reg_write_en:   dispatch_i.reg_write_en,
        reg_write_addr: dispatch_i.reg_write_addr,
        reg_write_data: result
    };

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_o.valid        <= 1'b0;
            ex_o.reg_write_en <= 1'b0;
        end else begin
            ex_o <= ex_next;
        end
    end

endmodule

// ==== dispatch.sv ====
module dispatch (
    input  logic                          clk,
    input  logic                          rst_i,
    input  pipeline_types::ctrl_t         ctrl_i,
    input  pipeline_types::id_dispatch_t  id_i,
    input  pipeline_types::bus32_t        reg1_data_i,
    input  pipeline_types::bus32_t        reg2_data_i,
    input  pipeline_types::push_forward_t ex_forward_i,
    input  pipeline_types::push_forward_t mem_forward_i,
    output pipeline_types::reg_addr_t     reg1_addr_o,
    output pipeline_types::reg_addr_t     reg2_addr_o,
    output logic                          pause_dispatch_o,
    output pipeline_types::dispatch_ex_t  dispatch_o
);
    import pipeline_types::*;

    bus32_t       reg1;
    bus32_t       reg2;
    dispatch_ex_t disp_next;

    function automatic bus32_t forward(input logic en, input reg_addr_t addr,
                                       input bus32_t rf_data);
        if (!en) begin
            return '0;
        end
        if (addr != 5'd0 && ex_forward_i.reg_write_en && ex_forward_i.reg_write_addr == addr) begin
            return ex_forward_i.reg_write_data;
        end
        if (addr != 5'd0 && mem_forward_i.reg_write_en
                && mem_forward_i.reg_write_addr == addr) begin
            return mem_forward_i.reg_write_data;
        end
        return rf_data;
    endfunction

    assign reg1_addr_o = id_i.reg1_read_addr;
    assign reg2_addr_o = id_i.reg2_read_addr;

    always_comb begin
        reg1 = forward(id_i.reg1_read_en, id_i.reg1_read_addr, reg1_data_i);
        reg2 = forward(id_i.reg2_read_en, id_i.reg2_read_addr, reg2_data_i);
        // load still in ex, its data is not there yet
        pause_dispatch_o = id_i.valid && ex_forward_i.aluop == ALU_LD
            && ex_forward_i.reg_write_en
            && ((id_i.reg1_read_en && id_i.reg1_read_addr == ex_forward_i.reg_write_addr)
             || (id_i.reg2_read_en && id_i.reg2_read_addr == ex_forward_i.reg_write_addr));
    end

    assign disp_next = '{
        pc:             id_i.pc,
        aluop:          id_i.aluop,
        operand1:       reg1,
        operand2:       id_i.reg2_read_en ? reg2 : id_i.imm,
        imm:            id_i.imm,
        store_data:     reg2,
        reg_write_en:   id_i.reg_write_en,
        reg_write_addr: id_i.reg_write_addr,
        valid:          id_i.valid
    };

    always_ff @(posedge clk) begin
        if (rst_i || ctrl_i.flush || ctrl_i.stall_dispatch) begin
            dispatch_o.valid        <= 1'b0;
            dispatch_o.reg_write_en <= 1'b0;
        end else begin
            dispatch_o <= disp_next;
        end
    end

endmodule

// ==== regfile.sv ====
module regfile (
    input  logic                      clk,
    input  logic                      rst_i,
    input  pipeline_types::reg_addr_t reg1_addr_i,
    input  pipeline_types::reg_addr_t reg2_addr_i,
    input  logic                      we_i,
    input  pipeline_types::reg_addr_t waddr_i,
    input  pipeline_types::bus32_t    wdata_i,
    output pipeline_types::bus32_t    reg1_data_o,
    output pipeline_types::bus32_t    reg2_data_o
);
    import pipeline_types::*;

    bus32_t regs [32];
    logic   wr;

    assign wr = we_i && (waddr_i != 5'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through of the commit in flight
    assign reg1_data_o = (wr && waddr_i == reg1_addr_i) ? wdata_i : regs[reg1_addr_i];
    assign reg2_data_o = (wr && waddr_i == reg2_addr_i) ? wdata_i : regs[reg2_addr_i];

endmodule

// ==== id.sv ====
module id (
    input  logic                         clk,
    input  logic                         rst_i,
    input  pipeline_types::ctrl_t        ctrl_i,
    input  pipeline_types::bus32_t       pc_i,
    input  pipeline_types::bus32_t       inst_i,
    output pipeline_types::id_dispatch_t id_o
);
    import pipeline_types::*;

    pc_id_t    pc_id_q;
    logic      valid_q;
    bus32_t    inst;
    reg_addr_t rd;

    always_ff @(posedge clk) begin
        if (rst_i || ctrl_i.flush) begin
            valid_q <= 1'b0;
        end else if (!ctrl_i.stall_id) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl_i.stall_id) begin
            pc_id_q <= '{pc: pc_i, inst: inst_i};
        end
    end

    assign inst = pc_id_q.inst;
    assign rd   = inst[4:0];

    always_comb begin
        logic writes;
        writes              = 1'b0;
        id_o                = '0;
        id_o.pc             = pc_id_q.pc;
        id_o.valid          = valid_q;
        id_o.aluop          = ALU_ADD;
        id_o.reg1_read_addr = inst[9:5];
        id_o.reg2_read_addr = inst[14:10];
        id_o.reg_write_addr = rd;
        // sign-extended si12 unless overridden below
        id_o.imm            = {{20{inst[21]}}, inst[21:10]};
        casez (inst[31:15])
            17'h00020, 17'h00022, 17'h00024, 17'h00029, 17'h0002a, 17'h0002b: begin
                case (inst[18:15])
                    4'h0:    id_o.aluop = ALU_ADD;
                    4'h2:    id_o.aluop = ALU_SUB;
                    4'h4:    id_o.aluop = ALU_SLT;
                    4'h9:    id_o.aluop = ALU_AND;
                    4'ha:    id_o.aluop = ALU_OR;
                    default: id_o.aluop = ALU_XOR;
                endcase
                id_o.reg1_read_en = 1'b1;
                id_o.reg2_read_en = 1'b1;
                writes            = 1'b1;
            end
            17'b0000001010_???????: begin
                id_o.reg1_read_en = 1'b1;
                writes            = 1'b1;
            end
            17'b0001010_??????????: begin
                id_o.aluop = ALU_LUI;
                id_o.imm   = {{12{inst[24]}}, inst[24:5]};
                writes     = 1'b1;
            end
            17'b0010100010_???????: begin
                id_o.aluop        = ALU_LD;
                id_o.reg1_read_en = 1'b1;
                writes            = 1'b1;
            end
            17'b0010100110_???????, 17'b01011?_???????????: begin
                // st.w, beq and bne compare or store rd
                id_o.reg1_read_en   = 1'b1;
                id_o.reg2_read_en   = 1'b1;
                id_o.reg2_read_addr = rd;
                if (inst[30]) begin
                    id_o.aluop = inst[26] ? ALU_BNE : ALU_BEQ;
                    id_o.imm   = {{16{inst[25]}}, inst[25:10]};
                end else begin
                    id_o.aluop = ALU_ST;
                end
            end
            17'b010100_???????????: begin
                id_o.aluop = ALU_B;
                id_o.imm   = {{6{inst[9]}}, inst[9:0], inst[25:10]};
            end
            default: ;
        endcase
        id_o.reg_write_en = valid_q && writes && (rd != 5'd0);
    end

endmodule

// ==== pc.sv ====
module pc #(
    parameter pipeline_types::bus32_t RESET_PC = pipeline_types::RESET_PC_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  pipeline_types::ctrl_t  ctrl_i,
    input  logic                   branch_flush_i,
    input  pipeline_types::bus32_t branch_target_i,
    output pipeline_types::bus32_t pc_o,
    output logic                   inst_en_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o      <= RESET_PC;
            inst_en_o <= 1'b0;
        end else begin
            inst_en_o <= 1'b1;
            // taken branch wins over a load-use hold
            if (branch_flush_i) begin
                pc_o <= branch_target_i;
            end else if (!ctrl_i.stall_pc) begin
                pc_o <= pc_o + 32'd4;
            end
        end
    end

endmodule

// ==== pipeline_types.sv ====
package pipeline_types;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  aluop_t;

    localparam bus32_t RESET_PC_DEFAULT = 32'h1c00_0000;

    localparam aluop_t ALU_ADD = 4'd0;
    localparam aluop_t ALU_SUB = 4'd1;
    localparam aluop_t ALU_AND = 4'd2;
    localparam aluop_t ALU_OR  = 4'd3;
    localparam aluop_t ALU_XOR = 4'd4;
    localparam aluop_t ALU_SLT = 4'd5;
    localparam aluop_t ALU_LUI = 4'd6;
    localparam aluop_t ALU_LD  = 4'd7;
    localparam aluop_t ALU_ST  = 4'd8;
    localparam aluop_t ALU_BEQ = 4'd9;
    localparam aluop_t ALU_BNE = 4'd10;
    localparam aluop_t ALU_B   = 4'd11;

    typedef struct packed {
        bus32_t pc;
        bus32_t inst;
    } pc_id_t;

    typedef struct packed {
        bus32_t    pc;
        aluop_t    aluop;
        logic      reg1_read_en;
        reg_addr_t reg1_read_addr;
        logic      reg2_read_en;
        reg_addr_t reg2_read_addr;
        bus32_t    imm;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        logic      valid;
    } id_dispatch_t;

    typedef struct packed {
        bus32_t    pc;
        aluop_t    aluop;
        bus32_t    operand1;
        bus32_t    operand2;
        bus32_t    imm;
        bus32_t    store_data;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        logic      valid;
    } dispatch_ex_t;

    typedef struct packed {
        bus32_t    pc;
        aluop_t    aluop;
        bus32_t    mem_addr;
        bus32_t    store_data;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_data;
        logic      valid;
    } ex_mem_t;

    typedef struct packed {
        bus32_t    pc;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_data;
        logic      valid;
    } mem_wb_t;

    typedef struct packed {
        aluop_t    aluop;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_data;
    } push_forward_t;

    typedef struct packed {
        logic stall_pc;
        logic stall_id;
        logic stall_dispatch;
        logic flush;
    } ctrl_t;

endpackage
